// File: Makefile
TOP := fetch_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f fetch_unit.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f fetch_unit.f

clean:
	rm -rf obj_dir

// File: common/fetch_cfg_pkg.sv
package fetch_cfg_pkg;

    // address and line geometry
    localparam int XLEN      = 32;
    localparam int LINE_BITS = 6;   // 64 byte lines

    // cacheline number drops the byte offset within a line
    localparam int CL_W = XLEN - LINE_BITS;

    // global branch history length
    localparam int BHR_W = 10;

    // default sizes, overridable from the top level
    localparam int RAS_DEPTH_DEF = 8;
    localparam int PF_DIST_DEF   = 1;   // in lines

endpackage

// File: common/fetch_types_pkg.sv
package fetch_types_pkg;

    // one cacheline number, address >> LINE_BITS
    typedef logic [fetch_cfg_pkg::CL_W-1:0] cl_t;

    // resteer request from ROB, decode or branch unit
    typedef struct packed {
        logic                          taken;
        logic [fetch_cfg_pkg::XLEN-1:0] target;
    } resteer_src_t;

    // history restore sent along with a predictor update
    typedef struct packed {
        logic                           update;
        logic [fetch_cfg_pkg::BHR_W-1:0] history;
    } bp_update_t;

    // call/return traffic for the return address stack
    typedef struct packed {
        logic                          valid;
        logic                          push;
        logic                          pop;
        logic [fetch_cfg_pkg::XLEN-1:0] ret_addr;
    } ras_op_t;

endpackage

// File: design/bhr_tracker.sv
`timescale 1ns/1ns

module bhr_tracker #(
    parameter int BHR_W = 10
) (
    input  logic                        clk,
    input  logic                        rst,
    input  fetch_types_pkg::bp_update_t upd_rob,
    input  fetch_types_pkg::bp_update_t upd_d1,
    input  fetch_types_pkg::bp_update_t upd_br,
    output logic [BHR_W-1:0]            bhr
);

    logic [BHR_W-1:0] hist_sel;
    logic             hist_load;

    // oldest source wins when several update in the same cycle
    always_comb begin
        hist_load = 1'b1;
        if (upd_rob.update) begin
            hist_sel = upd_rob.history;
        end else if (upd_d1.update) begin
            hist_sel = upd_d1.history;
        end else if (upd_br.update) begin
            hist_sel = upd_br.history;
        end else begin
            hist_sel  = bhr;
            hist_load = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bhr <= '0;
        end else if (hist_load) begin
            bhr <= hist_sel;
        end
    end

endmodule

// File: design/fetch_ctrl.sv
`timescale 1ns/1ns

module fetch_ctrl #(
    parameter int XLEN = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall,
    input  logic                          resteer,
    input  fetch_types_pkg::resteer_src_t rs_rob,
    input  fetch_types_pkg::resteer_src_t rs_d1,
    input  fetch_types_pkg::resteer_src_t rs_br,
    input  logic [XLEN-1:0]               ras_top,
    input  logic                          ras_valid,
    output fetch_types_pkg::cl_t          clc,
    output logic                          seq_adv
);

    fetch_types_pkg::cl_t clc_next;
    logic                 load_next;   // next value is a redirect, not a step

    // byte address to line number
    function automatic fetch_types_pkg::cl_t line_of(input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] shifted;
        shifted = addr >> fetch_cfg_pkg::LINE_BITS;
        return shifted[fetch_cfg_pkg::CL_W-1:0];
    endfunction

    // redirect priority: ROB, decode, branch unit, then return stack
    always_comb begin
        clc_next  = clc + fetch_types_pkg::cl_t'(1);
        load_next = 1'b0;
        if (resteer) begin
            if (rs_rob.taken) begin
                clc_next  = line_of(rs_rob.target);
                load_next = 1'b1;
            end else if (rs_d1.taken) begin
                clc_next  = line_of(rs_d1.target);
                load_next = 1'b1;
            end else if (rs_br.taken) begin
                clc_next  = line_of(rs_br.target);
                load_next = 1'b1;
            end else if (ras_valid) begin
                clc_next  = line_of(ras_top);
                load_next = 1'b1;
            end
            // no source and empty stack falls through to a plain step
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            clc     <= '0;
            seq_adv <= 1'b0;
        end else if (stall) begin
            seq_adv <= 1'b0;   // counter holds, nothing advanced this cycle
        end else begin
            clc     <= clc_next;
            seq_adv <= !load_next;   // only straight-line steps feed the prefetcher
        end
    end

endmodule

// File: design/fetch_top.sv
`timescale 1ns/1ns

module fetch_top #(
    parameter int XLEN      = fetch_cfg_pkg::XLEN,
    parameter int BHR_W     = fetch_cfg_pkg::BHR_W,
    parameter int RAS_DEPTH = fetch_cfg_pkg::RAS_DEPTH_DEF,
    parameter int PF_DIST   = fetch_cfg_pkg::PF_DIST_DEF
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall,
    input  logic                          resteer,
    input  fetch_types_pkg::resteer_src_t rs_rob,
    input  fetch_types_pkg::resteer_src_t rs_d1,
    input  fetch_types_pkg::resteer_src_t rs_br,
    input  fetch_types_pkg::bp_update_t   upd_rob,
    input  fetch_types_pkg::bp_update_t   upd_d1,
    input  fetch_types_pkg::bp_update_t   upd_br,
    input  fetch_types_pkg::ras_op_t      ras_op,
    output fetch_types_pkg::cl_t          clc,
    output logic [BHR_W-1:0]              bhr,
    output fetch_types_pkg::cl_t          nlpf,
    output logic                          nlpf_valid
);

    logic [XLEN-1:0] ras_top;
    logic            ras_valid;
    logic            seq_adv;

    ras #(
        .XLEN  (XLEN),
        .DEPTH (RAS_DEPTH)
    ) ras0 (
        .clk   (clk),
        .rst   (rst),
        .op    (ras_op),
        .top   (ras_top),
        .valid (ras_valid)
    );

    fetch_ctrl #(
        .XLEN (XLEN)
    ) ctrl0 (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .resteer   (resteer),
        .rs_rob    (rs_rob),
        .rs_d1     (rs_d1),
        .rs_br     (rs_br),
        .ras_top   (ras_top),
        .ras_valid (ras_valid),
        .clc       (clc),
        .seq_adv   (seq_adv)
    );

    bhr_tracker #(
        .BHR_W (BHR_W)
    ) bhr0 (
        .clk     (clk),
        .rst     (rst),
        .upd_rob (upd_rob),
        .upd_d1  (upd_d1),
        .upd_br  (upd_br),
        .bhr     (bhr)
    );

    // prefetcher works on line numbers, so its width drops the byte offset
    nlpf_gen #(
        .CL_W    (XLEN - fetch_cfg_pkg::LINE_BITS),
        .PF_DIST (PF_DIST)
    ) nlpf0 (
        .clk        (clk),
        .rst        (rst),
        .seq_adv    (seq_adv),
        .clc        (clc),
        .nlpf       (nlpf),
        .nlpf_valid (nlpf_valid)
    );

endmodule

// File: design/prefetch/nlpf_gen.sv
`timescale 1ns/1ns

module nlpf_gen #(
    parameter int CL_W    = 26,
    parameter int PF_DIST = 1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 seq_adv,
    input  fetch_types_pkg::cl_t clc,
    output fetch_types_pkg::cl_t nlpf,
    output logic                 nlpf_valid
);

    logic [CL_W-1:0] pf_line;

    // line PF_DIST ahead of the one being fetched now
    assign pf_line = clc + CL_W'(PF_DIST);

    // issue strobe follows seq_adv only, so redirects and stalls
    // never produce a prefetch
    always_ff @(posedge clk) begin
        if (rst) begin
            nlpf_valid <= 1'b0;
        end else begin
            nlpf_valid <= seq_adv;
        end
    end

    // address register, only meaningful while nlpf_valid is high
    always_ff @(posedge clk) begin
        if (seq_adv) begin
            nlpf <= pf_line;
        end
    end

endmodule

// File: design/ras/ras.sv
`timescale 1ns/1ns

module ras #(
    parameter int XLEN  = 32,
    parameter int DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  fetch_types_pkg::ras_op_t op,
    output logic [XLEN-1:0]          top,
    output logic                     valid
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [XLEN-1:0]  stack_mem [DEPTH];
    logic [PTR_W-1:0] top_ptr;   // index of the current top entry
    logic [CNT_W-1:0] count;     // live entries, saturates at DEPTH

    logic [PTR_W-1:0] ptr_up;
    logic [PTR_W-1:0] ptr_down;
    logic             is_empty;
    logic             is_full;

    // circular pointer arithmetic, works for any depth
    assign ptr_up   = (top_ptr == PTR_W'(DEPTH - 1)) ? '0 : top_ptr + 1'b1;
    assign ptr_down = (top_ptr == '0) ? PTR_W'(DEPTH - 1) : top_ptr - 1'b1;

    assign is_empty = (count == '0);
    assign is_full  = (count == CNT_W'(DEPTH));

    // pointer and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            top_ptr <= '0;
            count   <= '0;
        end else if (op.valid) begin
            if (op.push && op.pop) begin
                // replace in place; an empty stack just gains one entry
                if (is_empty) count <= CNT_W'(1);
            end else if (op.push) begin
                top_ptr <= ptr_up;
                if (!is_full) count <= count + 1'b1;   // full: oldest entry is lost
            end else if (op.pop && !is_empty) begin
                top_ptr <= ptr_down;
                count   <= count - 1'b1;
            end
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (op.valid && op.push) begin
            if (op.pop) begin
                stack_mem[top_ptr] <= op.ret_addr;
            end else begin
                stack_mem[ptr_up] <= op.ret_addr;
            end
        end
    end

    assign top   = stack_mem[top_ptr];
    assign valid = !is_empty;

endmodule

// File: fetch_unit.f
common/fetch_cfg_pkg.sv
common/fetch_types_pkg.sv
design/ras/ras.sv
design/bhr_tracker.sv
design/prefetch/nlpf_gen.sv
design/fetch_ctrl.sv
design/fetch_top.sv
sim/fetch_tb.sv

// File: sim/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb;

    localparam int XLEN      = fetch_cfg_pkg::XLEN;
    localparam int LINE_BITS = fetch_cfg_pkg::LINE_BITS;
    localparam int BHR_W     = fetch_cfg_pkg::BHR_W;
    localparam int RAS_DEPTH = fetch_cfg_pkg::RAS_DEPTH_DEF;
    localparam int PF_DIST   = fetch_cfg_pkg::PF_DIST_DEF;

    logic                          clk;
    logic                          rst;
    logic                          stall;
    logic                          resteer;
    fetch_types_pkg::resteer_src_t rs_rob;
    fetch_types_pkg::resteer_src_t rs_d1;
    fetch_types_pkg::resteer_src_t rs_br;
    fetch_types_pkg::bp_update_t   upd_rob;
    fetch_types_pkg::bp_update_t   upd_d1;
    fetch_types_pkg::bp_update_t   upd_br;
    fetch_types_pkg::ras_op_t      ras_op;
    fetch_types_pkg::cl_t          clc;
    logic [BHR_W-1:0]              bhr;
    fetch_types_pkg::cl_t          nlpf;
    logic                          nlpf_valid;

    // reference model state
    fetch_types_pkg::cl_t exp_clc;
    logic                 exp_seq;          // model copy of the advance strobe
    fetch_types_pkg::cl_t exp_nlpf;
    logic                 exp_nlpf_valid;
    logic [BHR_W-1:0]     exp_bhr;
    logic [XLEN-1:0]      model_stack[$];   // last element is the top

    int     errors;
    int     errors_at_start;
    int     tests_passed;
    int     tests_failed;
    integer seed;

    fetch_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .resteer    (resteer),
        .rs_rob     (rs_rob),
        .rs_d1      (rs_d1),
        .rs_br      (rs_br),
        .upd_rob    (upd_rob),
        .upd_d1     (upd_d1),
        .upd_br     (upd_br),
        .ras_op     (ras_op),
        .clc        (clc),
        .bhr        (bhr),
        .nlpf       (nlpf),
        .nlpf_valid (nlpf_valid)
    );

    always #20 clk = ~clk;

    // upper address bits are the line number
    function automatic fetch_types_pkg::cl_t target_line(input logic [XLEN-1:0] addr);
        return addr[XLEN-1:LINE_BITS];
    endfunction

    always @(posedge clk) begin : ref_model
        fetch_types_pkg::cl_t nxt;
        logic                 loaded;
        if (rst) begin
            exp_clc        <= '0;
            exp_seq        <= 1'b0;
            exp_nlpf_valid <= 1'b0;
            exp_bhr        <= '0;
            model_stack.delete();
        end else begin
            nxt    = exp_clc + fetch_types_pkg::cl_t'(1);
            loaded = 1'b0;
            if (resteer) begin
                if (rs_rob.taken) begin
                    nxt    = target_line(rs_rob.target);
                    loaded = 1'b1;
                end else if (rs_d1.taken) begin
                    nxt    = target_line(rs_d1.target);
                    loaded = 1'b1;
                end else if (rs_br.taken) begin
                    nxt    = target_line(rs_br.target);
                    loaded = 1'b1;
                end else if (model_stack.size() != 0) begin
                    nxt    = target_line(model_stack[model_stack.size()-1]);
                    loaded = 1'b1;
                end
            end
            if (stall) begin
                exp_seq <= 1'b0;   // counter frozen
            end else begin
                exp_clc <= nxt;
                exp_seq <= !loaded;
            end

            exp_nlpf_valid <= exp_seq;
            if (exp_seq) exp_nlpf <= exp_clc + fetch_types_pkg::cl_t'(PF_DIST);

            if (upd_rob.update) exp_bhr <= upd_rob.history;
            else if (upd_d1.update) exp_bhr <= upd_d1.history;
            else if (upd_br.update) exp_bhr <= upd_br.history;

            // stack updates after the counter has used the old top
            if (ras_op.valid) begin
                if (ras_op.push && ras_op.pop) begin
                    if (model_stack.size() == 0) model_stack.push_back(ras_op.ret_addr);
                    else model_stack[model_stack.size()-1] = ras_op.ret_addr;
                end else if (ras_op.push) begin
                    model_stack.push_back(ras_op.ret_addr);
                    if (model_stack.size() > RAS_DEPTH) void'(model_stack.pop_front());
                end else if (ras_op.pop && model_stack.size() != 0) begin
                    void'(model_stack.pop_back());
                end
            end
        end
    end

    clc_check: assert property (@(posedge clk) disable iff (rst) clc == exp_clc)
        else begin
            errors = errors + 1;
            $display("MISMATCH at %0t: clc is %h, expected %h", $time, $sampled(clc),
                     $sampled(exp_clc));
        end

    bhr_check: assert property (@(posedge clk) disable iff (rst) bhr == exp_bhr)
        else begin
            errors = errors + 1;
            $display("MISMATCH at %0t: bhr is %h, expected %h", $time, $sampled(bhr),
                     $sampled(exp_bhr));
        end

    pf_valid_check: assert property (@(posedge clk) disable iff (rst)
                                     nlpf_valid == exp_nlpf_valid)
        else begin
            errors = errors + 1;
            $display("MISMATCH at %0t: nlpf_valid is %b, expected %b", $time,
                     $sampled(nlpf_valid), $sampled(exp_nlpf_valid));
        end

    // address only matters while the strobe is up
    pf_addr_check: assert property (@(posedge clk) disable iff (rst)
                                    !exp_nlpf_valid || nlpf == exp_nlpf)
        else begin
            errors = errors + 1;
            $display("MISMATCH at %0t: nlpf is %h, expected %h", $time, $sampled(nlpf),
                     $sampled(exp_nlpf));
        end

    task automatic clear_inputs();
        stall   = 1'b0;
        resteer = 1'b0;
        rs_rob  = '0;
        rs_d1   = '0;
        rs_br   = '0;
        upd_rob = '0;
        upd_d1  = '0;
        upd_br  = '0;
        ras_op  = '0;
    endtask

    // inputs set before this call are sampled at the coming edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
        clear_inputs();
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic stall_for(input int n);
        repeat (n) begin
            stall = 1'b1;
            next_cycle();
        end
    endtask

    // taken bits are [2] rob, [1] decode and [0] branch unit
    task automatic resteer_with(input logic [2:0] taken);
        resteer       = 1'b1;
        rs_rob.taken  = taken[2];
        rs_rob.target = $random(seed);
        rs_d1.taken   = taken[1];
        rs_d1.target  = $random(seed);
        rs_br.taken   = taken[0];
        rs_br.target  = $random(seed);
        next_cycle();
    endtask

    task automatic update_history(input logic [2:0] which);
        upd_rob.update  = which[2];
        upd_rob.history = BHR_W'($random(seed));
        upd_d1.update   = which[1];
        upd_d1.history  = BHR_W'($random(seed));
        upd_br.update   = which[0];
        upd_br.history  = BHR_W'($random(seed));
        next_cycle();
    endtask

    task automatic stack_op(input logic push, input logic pop);
        ras_op.valid    = 1'b1;
        ras_op.push     = push;
        ras_op.pop      = pop;
        ras_op.ret_addr = $random(seed);
        next_cycle();
    endtask

    task automatic wait_for_prefetch(input int limit);
        int n;
        n = 0;
        while (nlpf_valid !== 1'b1 && n < limit) begin
            next_cycle();
            n++;
        end
        if (nlpf_valid !== 1'b1) begin
            errors = errors + 1;
            $display("timeout: no prefetch was issued within %0d cycles", limit);
        end
    endtask

    task automatic end_test(input string name);
        idle_cycles(2);   // let the last response reach the checks
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    task automatic history_test();
        int w;
        for (w = 1; w < 8; w++) begin
            update_history(3'(w));
            idle_cycles(2);   // holds with no strobe
        end
        stall = 1'b1;   // history ignores stall
        upd_d1.update  = 1'b1;
        upd_d1.history = BHR_W'($random(seed));
        next_cycle();
        end_test("history");
    endtask

    task automatic ras_fallback_test();
        int i;
        for (i = 0; i < 3; i++) stack_op(1'b1, 1'b0);
        resteer_with(3'b000);
        stack_op(1'b0, 1'b1);
        resteer_with(3'b000);
        for (i = 0; i < RAS_DEPTH + 3; i++) stack_op(1'b1, 1'b0);   // wraps
        resteer_with(3'b000);
        stack_op(1'b1, 1'b1);
        resteer_with(3'b000);
        // redirect in the same cycle as a push still sees the old top
        resteer = 1'b1;
        stack_op(1'b1, 1'b0);
        for (i = 0; i < RAS_DEPTH + 2; i++) begin
            stack_op(1'b0, 1'b1);
            resteer_with(3'b000);
        end
        resteer_with(3'b000);   // empty stack steps
        stack_op(1'b1, 1'b1);
        resteer_with(3'b000);
        stack_op(1'b0, 1'b1);
        end_test("ras fallback");
    endtask

    initial begin
        int f;
        clk             = 1'b0;
        rst             = 1'b1;
        seed            = 32'h3efa;
        errors          = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        clear_inputs();
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        idle_cycles(12);
        end_test("reset and advance");

        stall_for(1);
        idle_cycles(2);
        stall_for(3);
        idle_cycles(1);
        stall_for(9);
        stall = 1'b1;   // stall wins over a redirect
        resteer_with(3'b100);
        end_test("stall");

        for (f = 0; f < 16; f++) begin
            resteer_with(3'(f));
            if (f[3]) idle_cycles(1);
        end
        end_test("resteer priority");

        ras_fallback_test();
        history_test();

        idle_cycles(3);
        resteer_with(3'b100);
        next_cycle();   // drains the pulse of the step before the redirect
        wait_for_prefetch(5);
        stall_for(4);
        wait_for_prefetch(5);
        resteer_with(3'b010);
        resteer_with(3'b001);
        wait_for_prefetch(5);
        end_test("prefetch");

        $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
